// File: src/xgmii_pkg.sv
// XGMII definitions
// Lane widths, word types and control characters for the 64-bit
// XGMII path, plus the 72-bit interleaved word used by the PHY.

package xgmii_pkg;

    // Byte lanes per XGMII word
    localparam int LANES = 8;

    // Data word, lane 0 in the lowest byte
    typedef logic [LANES*8-1:0] data_t;

    // One control flag per lane
    typedef logic [LANES-1:0] ctrl_t;

    // Interleaved PHY word
    // Lane i occupies bits 9i+8:9i, control flag on top
    typedef logic [LANES*9-1:0] dc_t;

    // Control characters carried in lanes with the control flag set
    typedef enum logic [7:0] {
        CTRL_IDLE      = 8'h07,
        CTRL_START     = 8'hFB,
        CTRL_TERMINATE = 8'hFD,
        CTRL_ERROR     = 8'hFE
    } ctrl_char_e;

    // All lanes idle control, the line state between frames
    localparam dc_t IDLE_DC = {LANES{1'b1, CTRL_IDLE}};

endpackage

// File: src/board_pkg.sv
// Board defaults
// Counter width and button debounce settings for the port top level.
// The debounce rate assumes a 156.25 MHz XGMII clock, so one sample
// every millisecond.

package board_pkg;

    // Width of the frame and error counters
    localparam int COUNT_WIDTH_DEF = 16;

    // Equal samples needed before the button level changes
    localparam int DEBOUNCE_N_DEF = 4;

    // Clocks between button samples
    localparam int DEBOUNCE_RATE_DEF = 156250;

endpackage

// File: src/xgmii_deinterleave.sv
// XGMII deinterleave stage
// Splits the 72-bit interleaved PHY word into 64 data bits and
// 8 control bits, one register stage.

module xgmii_deinterleave (
    input  logic             clk,
    input  logic             rst_i,
    input  xgmii_pkg::dc_t   dc_i,
    output xgmii_pkg::data_t d_o,
    output xgmii_pkg::ctrl_t c_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // Line idles until traffic arrives
            for (int i = 0; i < xgmii_pkg::LANES; i++) begin
                d_o[8*i +: 8] <= xgmii_pkg::IDLE_DC[9*i +: 8];
                c_o[i]        <= xgmii_pkg::IDLE_DC[9*i + 8];
            end
        end else begin
            for (int i = 0; i < xgmii_pkg::LANES; i++) begin
                d_o[8*i +: 8] <= dc_i[9*i +: 8];
                c_o[i]        <= dc_i[9*i + 8];
            end
        end
    end

endmodule

// File: src/xgmii_frame_tracker.sv
// XGMII frame tracker
// Follows start and terminate control characters on the receive
// stream, counts complete frames and protocol errors, and registers
// the word through unchanged for the transmit side.

module xgmii_frame_tracker #(
    parameter int COUNT_WIDTH = board_pkg::COUNT_WIDTH_DEF
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  xgmii_pkg::data_t       d_i,
    input  xgmii_pkg::ctrl_t       c_i,
    input  logic                   clear_i,
    output xgmii_pkg::data_t       d_o,
    output xgmii_pkg::ctrl_t       c_o,
    output logic [COUNT_WIDTH-1:0] frame_count_o,
    output logic [COUNT_WIDTH-1:0] error_count_o,
    output logic                   in_frame_o
);

    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } state_e;

    state_e state_q;
    state_e state_d;

    logic lane_start;
    logic lane_term;
    logic lane_err;
    logic err_word;
    logic frame_done;

    // Control character decode
    // Start is only legal in lane 0, terminate may sit in any lane
    always_comb begin
        lane_start = c_i[0] && (d_i[7:0] == xgmii_pkg::CTRL_START);
        lane_term  = 1'b0;
        lane_err   = 1'b0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (c_i[i] && (d_i[8*i +: 8] == xgmii_pkg::CTRL_TERMINATE)) begin
                lane_term = 1'b1;
            end
            if (c_i[i] && (d_i[8*i +: 8] == xgmii_pkg::CTRL_ERROR)) begin
                lane_err = 1'b1;
            end
        end
    end

    // Frame state and error classification
    always_comb begin
        err_word = lane_err
                || (state_q == ST_FRAME && lane_start)
                || (state_q == ST_IDLE && lane_term);

        // An error word leaves the state alone, so it never ends a frame
        frame_done = !err_word && (state_q == ST_FRAME) && lane_term;

        state_d = state_q;
        if (!err_word) begin
            case (state_q)
                ST_IDLE: begin
                    if (lane_start) begin
                        state_d = ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (lane_term) begin
                        state_d = ST_IDLE;
                    end
                end
                default: begin
                    state_d = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= ST_IDLE;
            frame_count_o <= '0;
            error_count_o <= '0;
        end else begin
            state_q <= state_d;
            // Clear wins over a count in the same clock
            if (clear_i) begin
                frame_count_o <= '0;
                error_count_o <= '0;
            end else begin
                if (frame_done) begin
                    frame_count_o <= frame_count_o + COUNT_WIDTH'(1);
                end
                if (err_word) begin
                    error_count_o <= error_count_o + COUNT_WIDTH'(1);
                end
            end
        end
    end

    // Word pass-through, aligned with the state and counters
    always_ff @(posedge clk) begin
        if (rst_i) begin
            d_o <= {xgmii_pkg::LANES{xgmii_pkg::CTRL_IDLE}};
            c_o <= '1;
        end else begin
            d_o <= d_i;
            c_o <= c_i;
        end
    end

    assign in_frame_o = (state_q == ST_FRAME);

endmodule

// File: src/xgmii_interleave.sv
// XGMII interleave stage
// Packs 64 data bits and 8 control bits into the 72-bit PHY word,
// one register stage.

module xgmii_interleave (
    input  logic             clk,
    input  logic             rst_i,
    input  xgmii_pkg::data_t d_i,
    input  xgmii_pkg::ctrl_t c_i,
    output xgmii_pkg::dc_t   dc_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // Transmit idles while in reset
            dc_o <= xgmii_pkg::IDLE_DC;
        end else begin
            // Data byte low, control flag in bit 8 of each group
            for (int i = 0; i < xgmii_pkg::LANES; i++) begin
                dc_o[9*i +: 8] <= d_i[8*i +: 8];
                dc_o[9*i + 8]  <= c_i[i];
            end
        end
    end

endmodule

// File: src/debounce_switch.sv
// Switch debouncer
// Synchronizes a mechanical input, samples it once every DEBOUNCE_RATE
// clocks and reports a level only after DEBOUNCE_N equal samples.

module debounce_switch #(
    parameter int DEBOUNCE_N    = board_pkg::DEBOUNCE_N_DEF,
    parameter int DEBOUNCE_RATE = board_pkg::DEBOUNCE_RATE_DEF
) (
    input  logic clk,
    input  logic rst_i,
    input  logic in_i,
    output logic out_o
);

    localparam int CNT_W = $clog2(DEBOUNCE_RATE + 1);

    logic [CNT_W-1:0]      prescale_q;
    logic                  tick;
    logic [1:0]            sync_q;
    logic [DEBOUNCE_N-1:0] samples_q;

    assign tick = (prescale_q == CNT_W'(DEBOUNCE_RATE - 1));

    // Sample tick generator
    always_ff @(posedge clk) begin
        if (rst_i || tick) begin
            prescale_q <= '0;
        end else begin
            prescale_q <= prescale_q + CNT_W'(1);
        end
    end

    // Input is asynchronous to the clock
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], in_i};
        end
    end

    // Level decided from the stored history on each tick,
    // then the newest sample shifted in
    always_ff @(posedge clk) begin
        if (rst_i) begin
            samples_q <= '0;
            out_o     <= 1'b0;
        end else if (tick) begin
            samples_q <= DEBOUNCE_N'({samples_q, sync_q[1]});
            if (&samples_q) begin
                out_o <= 1'b1;
            end else if (~|samples_q) begin
                out_o <= 1'b0;
            end
        end
    end

endmodule

// File: src/xgmii_port_top.sv
// 10G Ethernet port top level
// Receive monitor with transmit loopback: the PHY word is split,
// tracked for frames and errors, and packed back for transmit,
// three clocks end to end. A debounced push button clears the
// frame and error counters.

module xgmii_port_top #(
    parameter int COUNT_WIDTH   = board_pkg::COUNT_WIDTH_DEF,
    parameter int DEBOUNCE_N    = board_pkg::DEBOUNCE_N_DEF,
    parameter int DEBOUNCE_RATE = board_pkg::DEBOUNCE_RATE_DEF
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  xgmii_pkg::dc_t         rx_dc_i,
    input  logic                   clear_button_i,
    output xgmii_pkg::dc_t         tx_dc_o,
    output logic [COUNT_WIDTH-1:0] frame_count_o,
    output logic [COUNT_WIDTH-1:0] error_count_o,
    output logic                   in_frame_o
);

    xgmii_pkg::data_t rx_d;
    xgmii_pkg::ctrl_t rx_c;
    xgmii_pkg::data_t mon_d;
    xgmii_pkg::ctrl_t mon_c;

    logic button_level;
    logic button_level_q;
    logic clear_pulse;

    // Receive path from the PHY
    xgmii_deinterleave i_xgmii_deinterleave (
        .clk   (clk),
        .rst_i (rst_i),
        .dc_i  (rx_dc_i),
        .d_o   (rx_d),
        .c_o   (rx_c)
    );

    xgmii_frame_tracker #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_xgmii_frame_tracker (
        .clk           (clk),
        .rst_i         (rst_i),
        .d_i           (rx_d),
        .c_i           (rx_c),
        .clear_i       (clear_pulse),
        .d_o           (mon_d),
        .c_o           (mon_c),
        .frame_count_o (frame_count_o),
        .error_count_o (error_count_o),
        .in_frame_o    (in_frame_o)
    );

    // Loopback to the PHY transmit side
    xgmii_interleave i_xgmii_interleave (
        .clk   (clk),
        .rst_i (rst_i),
        .d_i   (mon_d),
        .c_i   (mon_c),
        .dc_o  (tx_dc_o)
    );

    debounce_switch #(
        .DEBOUNCE_N    (DEBOUNCE_N),
        .DEBOUNCE_RATE (DEBOUNCE_RATE)
    ) i_debounce_switch (
        .clk   (clk),
        .rst_i (rst_i),
        .in_i  (clear_button_i),
        .out_o (button_level)
    );

    // One clear per press, on the rising edge of the stable level
    always_ff @(posedge clk) begin
        if (rst_i) begin
            button_level_q <= 1'b0;
        end else begin
            button_level_q <= button_level;
        end
    end

    assign clear_pulse = button_level && !button_level_q;

endmodule

// File: bench/tb_clock_gen.sv
// Testbench clock and reset source
// Free running clock, reset held high for a fixed number of rising edges.

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Release away from the edge so the DUT sees a clean synchronous reset
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: bench/tb_xgmii_port_top.sv
// Testbench for the 10G port top level
// Drives XGMII words and the clear button, keeps a reference model of
// the frame tracker rules and checks the DUT against it with assertions.

module tb_xgmii_port_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CW      = board_pkg::COUNT_WIDTH_DEF;
    localparam int DB_N    = 3;
    localparam int DB_RATE = 4;
    localparam int HOLD    = (DB_N + 2) * DB_RATE;

    logic             clk;
    logic             rst;
    xgmii_pkg::dc_t   rx_dc_i;
    logic             clear_button_i;
    xgmii_pkg::dc_t   tx_dc_o;
    logic [CW-1:0]    frame_count_o;
    logic [CW-1:0]    error_count_o;
    logic             in_frame_o;

    // Reference model state
    xgmii_pkg::dc_t hist [3] = '{default: xgmii_pkg::IDLE_DC};
    logic           m_in_frame;
    logic [CW-1:0]  m_frames;
    logic [CW-1:0]  m_errors;
    logic           model_zero;
    logic           clear_window;

    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          test_err_base;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen i_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    xgmii_port_top #(
        .COUNT_WIDTH   (CW),
        .DEBOUNCE_N    (DB_N),
        .DEBOUNCE_RATE (DB_RATE)
    ) i_xgmii_port_top (
        .clk            (clk),
        .rst_i          (rst),
        .rx_dc_i        (rx_dc_i),
        .clear_button_i (clear_button_i),
        .tx_dc_o        (tx_dc_o),
        .frame_count_o  (frame_count_o),
        .error_count_o  (error_count_o),
        .in_frame_o     (in_frame_o)
    );

    // Model works on the word one clock after it was presented,
    // which lines it up with the tracker outputs
    always @(posedge clk) begin : model_step
        xgmii_pkg::dc_t w;
        logic is_start;
        logic is_term;
        logic is_err;
        logic bad;
        w        = hist[0];
        is_start = w[8] && (w[7:0] == xgmii_pkg::CTRL_START);
        is_term  = 1'b0;
        is_err   = 1'b0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (w[9*i + 8] && (w[9*i +: 8] == xgmii_pkg::CTRL_TERMINATE)) begin
                is_term = 1'b1;
            end
            if (w[9*i + 8] && (w[9*i +: 8] == xgmii_pkg::CTRL_ERROR)) begin
                is_err = 1'b1;
            end
        end
        bad = is_err || (m_in_frame && is_start) || (!m_in_frame && is_term);
        hist[0] <= rx_dc_i;
        hist[1] <= hist[0];
        hist[2] <= hist[1];
        if (rst) begin
            m_in_frame <= 1'b0;
            m_frames   <= '0;
            m_errors   <= '0;
        end else begin
            if (!bad && !m_in_frame && is_start) begin
                m_in_frame <= 1'b1;
            end
            if (!bad && m_in_frame && is_term) begin
                m_in_frame <= 1'b0;
            end
            if (model_zero) begin
                m_frames <= '0;
                m_errors <= '0;
            end else begin
                if (!bad && m_in_frame && is_term) begin
                    m_frames <= m_frames + 1'b1;
                end
                if (bad) begin
                    m_errors <= m_errors + 1'b1;
                end
            end
        end
    end

    a_tx_loopback: assert property (@(posedge clk) disable iff (rst)
        tx_dc_o == hist[2])
        else report_mismatch("tx_dc_o", $sampled(hist[2]), $sampled(tx_dc_o));

    a_frame_count: assert property (@(posedge clk) disable iff (rst || clear_window)
        frame_count_o == m_frames)
        else report_mismatch("frame_count_o", $sampled(m_frames), $sampled(frame_count_o));

    a_error_count: assert property (@(posedge clk) disable iff (rst || clear_window)
        error_count_o == m_errors)
        else report_mismatch("error_count_o", $sampled(m_errors), $sampled(error_count_o));

    a_in_frame: assert property (@(posedge clk) disable iff (rst)
        in_frame_o == m_in_frame)
        else report_mismatch("in_frame_o", $sampled(m_in_frame), $sampled(in_frame_o));

    task automatic report_mismatch(input string what, input logic [71:0] exp,
                                   input logic [71:0] act);
        errors++;
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic expect_eq(input string what, input logic [71:0] exp,
                             input logic [71:0] act);
        assert (exp === act) else report_mismatch(what, exp, act);
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        if (errors == test_err_base) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Lane i is the 9-bit group at bit 9i, control flag on top
    function automatic xgmii_pkg::dc_t set_lane(input xgmii_pkg::dc_t w, input int lane,
                                                input logic c, input logic [7:0] b);
        w[9*lane +: 9] = {c, b};
        return w;
    endfunction

    function automatic xgmii_pkg::dc_t random_word();
        xgmii_pkg::dc_t w;
        logic [31:0]    r;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            r = next_rand();
            w = set_lane(w, i, r[8], r[7:0]);
        end
        return w;
    endfunction

    function automatic xgmii_pkg::dc_t data_word();
        xgmii_pkg::dc_t w;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            w = set_lane(w, i, 1'b0, 8'(next_rand()));
        end
        return w;
    endfunction

    // Start in lane 0 followed by preamble and SFD
    function automatic xgmii_pkg::dc_t start_word();
        xgmii_pkg::dc_t w;
        w = set_lane(w, 0, 1'b1, xgmii_pkg::CTRL_START);
        for (int i = 1; i < xgmii_pkg::LANES - 1; i++) begin
            w = set_lane(w, i, 1'b0, 8'h55);
        end
        w = set_lane(w, xgmii_pkg::LANES - 1, 1'b0, 8'hD5);
        return w;
    endfunction

    function automatic xgmii_pkg::dc_t term_word(input int lane);
        xgmii_pkg::dc_t w;
        w = xgmii_pkg::IDLE_DC;
        for (int i = 0; i < lane; i++) begin
            w = set_lane(w, i, 1'b0, 8'(next_rand()));
        end
        w = set_lane(w, lane, 1'b1, xgmii_pkg::CTRL_TERMINATE);
        return w;
    endfunction

    function automatic xgmii_pkg::dc_t error_word(input int lane);
        return set_lane(data_word(), lane, 1'b1, xgmii_pkg::CTRL_ERROR);
    endfunction

    task automatic drive(input xgmii_pkg::dc_t w);
        @(posedge clk);
        #1;
        rx_dc_i = w;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive(xgmii_pkg::IDLE_DC);
    endtask

    task automatic set_button(input logic level);
        @(posedge clk);
        #1;
        clear_button_i = level;
    endtask

    task automatic send_frame();
        int n;
        n = int'(next_rand() % 6) + 1;
        drive(start_word());
        repeat (n) drive(data_word());
        drive(term_word(int'(next_rand() % 8)));
        drive(xgmii_pkg::IDLE_DC);
    endtask

    // Leaves the line idle and the model outside a frame
    task automatic settle_idle();
        idle_cycles(4);
        if (m_in_frame) begin
            drive(term_word(0));
            idle_cycles(4);
        end
    endtask

    task automatic wait_reset_release(input int limit);
        bit done;
        done = 1'b0;
        for (int k = 0; k < limit && !done; k++) begin
            @(negedge clk);
            done = !rst;
        end
        if (!done) begin
            errors++;
            $display("Timeout in %s: reset still active after %0d clocks", test_name, limit);
        end
    endtask

    task automatic wait_counts(input logic [CW-1:0] frames, input logic [CW-1:0] errs,
                               input int limit);
        bit done;
        done = 1'b0;
        for (int k = 0; k < limit && !done; k++) begin
            @(posedge clk);
            #1;
            done = (frame_count_o == frames) && (error_count_o == errs);
        end
        if (!done) begin
            errors++;
            $display("Timeout in %s: counters did not reach %0d frames and %0d errors in %0d clocks",
                     test_name, frames, errs, limit);
        end
    endtask

    initial begin
        logic [CW-1:0] base_f;
        logic [CW-1:0] base_e;
        int            zero_at;
        rx_dc_i        = xgmii_pkg::IDLE_DC;
        clear_button_i = 1'b0;
        model_zero     = 1'b0;
        clear_window   = 1'b0;
        rng_state      = 32'h6515_b9eb;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;

        begin_test("reset_state");
        wait_reset_release(20);
        expect_eq("frame_count_o", 0, frame_count_o);
        expect_eq("error_count_o", 0, error_count_o);
        expect_eq("in_frame_o", 0, in_frame_o);
        expect_eq("tx_dc_o", xgmii_pkg::IDLE_DC, tx_dc_o);
        end_test();

        begin_test("pass_through");
        repeat (200) drive(random_word());
        settle_idle();
        end_test();

        begin_test("good_frames");
        base_f = m_frames;
        base_e = m_errors;
        repeat (10) send_frame();
        wait_counts(base_f + 10, base_e, 200);
        idle_cycles(4);
        expect_eq("frame_count_o", base_f + 10, frame_count_o);
        expect_eq("error_count_o", base_e, error_count_o);
        end_test();

        begin_test("error_ctrl_char");
        base_f = m_frames;
        base_e = m_errors;
        drive(error_word(3));
        drive(xgmii_pkg::IDLE_DC);
        wait_counts(base_f, base_e + 1, 20);
        idle_cycles(4);
        expect_eq("error_count_o", base_e + 1, error_count_o);
        expect_eq("in_frame_o", 0, in_frame_o);
        end_test();

        begin_test("error_term_idle");
        base_f = m_frames;
        base_e = m_errors;
        drive(term_word(int'(next_rand() % 8)));
        drive(xgmii_pkg::IDLE_DC);
        wait_counts(base_f, base_e + 1, 20);
        idle_cycles(4);
        expect_eq("error_count_o", base_e + 1, error_count_o);
        expect_eq("in_frame_o", 0, in_frame_o);
        end_test();

        begin_test("error_double_start");
        base_f = m_frames;
        base_e = m_errors;
        drive(start_word());
        drive(data_word());
        drive(start_word());
        drive(data_word());
        wait_counts(base_f, base_e + 1, 20);
        repeat (3) drive(data_word());
        // Frame stays open after the bad start
        expect_eq("in_frame_o", 1, in_frame_o);
        drive(term_word(5));
        drive(xgmii_pkg::IDLE_DC);
        wait_counts(base_f + 1, base_e + 1, 20);
        idle_cycles(4);
        expect_eq("error_count_o", base_e + 1, error_count_o);
        expect_eq("in_frame_o", 0, in_frame_o);
        end_test();

        begin_test("clear_short_pulse");
        base_f = m_frames;
        base_e = m_errors;
        set_button(1'b1);
        set_button(1'b0);
        idle_cycles(2 * HOLD);
        expect_eq("frame_count_o", base_f, frame_count_o);
        expect_eq("error_count_o", base_e, error_count_o);
        end_test();

        begin_test("clear_press");
        clear_window = 1'b1;
        set_button(1'b1);
        zero_at = 0;
        for (int k = 1; k <= HOLD; k++) begin
            @(posedge clk);
            #1;
            if (zero_at == 0 && frame_count_o == 0 && error_count_o == 0) begin
                zero_at = k;
            end
        end
        clear_button_i = 1'b0;
        if (zero_at == 0) begin
            errors++;
            $display("Timeout in %s: counters not cleared within %0d clocks", test_name, HOLD);
        end else if (zero_at < DB_N * DB_RATE + 1 || zero_at > (DB_N + 1) * DB_RATE + 3) begin
            errors++;
            $display("Counters in %s cleared after %0d clocks, outside the debounce window",
                     test_name, zero_at);
        end
        idle_cycles(HOLD);
        model_zero = 1'b1;
        @(posedge clk);
        #1;
        model_zero   = 1'b0;
        clear_window = 1'b0;
        // Counting resumes from zero
        repeat (3) send_frame();
        wait_counts(3, 0, 100);
        idle_cycles(4);
        expect_eq("frame_count_o", 3, frame_count_o);
        expect_eq("error_count_o", 0, error_count_o);
        end_test();

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
src/xgmii_pkg.sv
src/board_pkg.sv
src/xgmii_deinterleave.sv
src/xgmii_frame_tracker.sv
src/xgmii_interleave.sv
src/debounce_switch.sv
src/xgmii_port_top.sv
bench/tb_clock_gen.sv
bench/tb_xgmii_port_top.sv
